// ==== logic/riscv_ctrl_defs.svh ====
`ifndef RISCV_CTRL_DEFS_SVH
`define RISCV_CTRL_DEFS_SVH

// Data path word width
`define XLEN 32

// Instruction word width
`define ILEN 32

// Width of the funct3 field
`define FUNCT3_W 3

// Width of the instruction slice that carries immediate bits (31 to 7)
`define IMM_FIELD_W 25

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

// ==== logic/riscv_ctrl_pkg.sv ====
package riscv_ctrl_pkg;

    // Base opcodes handled by the decode stage
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP     = 7'b0110011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        AUIPC  = 7'b0010111,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } imm_src_e;

    // Write-back source for the register file
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } result_src_e;

    // Coarse ALU class from the main decoder
    typedef enum logic [1:0] {
        CLS_ADD   = 2'b00,
        CLS_SUB   = 2'b01,
        CLS_FUNC  = 2'b10,
        CLS_PASSB = 2'b11
    } alu_class_e;

    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        SLL   = 4'd2,
        SLT   = 4'd3,
        SLTU  = 4'd4,
        XOR   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,
        OR    = 4'd8,
        AND   = 4'd9,
        PASSB = 4'd10  // Operand B straight through
    } alu_op_e;

endpackage

// ==== logic/main_decoder.sv ====
`timescale 1ns/1ps

module main_decoder
    import riscv_ctrl_pkg::*;
(
    input  logic [6:0]  op_i,         // Instruction opcode

    output logic        reg_write_o,  // Register write enable
    output logic        mem_write_o,  // Memory write enable
    output logic        alu_src_o,    // Immediate as ALU operand B
    output logic        pc_as_a_o,    // PC as ALU operand A
    output logic        branch_o,     // Conditional branch
    output logic        jump_o,       // Unconditional jump
    output logic        jalr_o,       // Jump target from register
    output logic        illegal_o,    // Opcode not recognised
    output result_src_e result_src_o,
    output imm_src_e    imm_src_o,
    output alu_class_e  alu_class_o
);

    always_comb
    begin
        // Bubble unless a row below says otherwise
        reg_write_o  = 1'b0;
        mem_write_o  = 1'b0;
        alu_src_o    = 1'b0;
        pc_as_a_o    = 1'b0;
        branch_o     = 1'b0;
        jump_o       = 1'b0;
        jalr_o       = 1'b0;
        illegal_o    = 1'b0;
        result_src_o = RES_ALU;
        imm_src_o    = IMM_I;
        alu_class_o  = CLS_ADD;

        case (opcode_e'(op_i))
            LOAD:
            begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = RES_MEM;  // Base plus offset
            end
            STORE:
            begin
                mem_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = IMM_S;
            end
            OP:
            begin
                reg_write_o = 1'b1;
                alu_class_o = CLS_FUNC;
            end
            OP_IMM:
            begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_class_o = CLS_FUNC;
            end
            BRANCH:
            begin
                branch_o    = 1'b1;
                imm_src_o   = IMM_B;
                alu_class_o = CLS_SUB;  // Compare rs1 against rs2
            end
            JAL:
            begin
                reg_write_o  = 1'b1;
                jump_o       = 1'b1;
                imm_src_o    = IMM_J;
                result_src_o = RES_PC4;  // Link address
            end
            JALR:
            begin
                reg_write_o  = 1'b1;
                jump_o       = 1'b1;
                jalr_o       = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = RES_PC4;
            end
            AUIPC:
            begin
                reg_write_o = 1'b1;
                imm_src_o   = IMM_U;
                pc_as_a_o   = 1'b1;  // PC plus upper immediate
                alu_src_o   = 1'b1;
            end
            LUI:
            begin
                reg_write_o = 1'b1;
                imm_src_o   = IMM_U;
                alu_src_o   = 1'b1;
                alu_class_o = CLS_PASSB;
            end
            default:
            begin
                illegal_o = 1'b1;  // Enables stay low
            end
        endcase
    end

endmodule

// ==== logic/alu_decoder.sv ====
`timescale 1ns/1ps

`include "riscv_ctrl_defs.svh"

module alu_decoder
    import riscv_ctrl_pkg::*;
(
    input  alu_class_e           alu_class_i,  // Class from main decoder
    input  logic [`FUNCT3_W-1:0] funct3_i,
    input  logic                 funct7_b5_i,
    input  logic                 op_b5_i,      // Set for register forms
    output alu_op_e              alu_op_o
);

    always_comb
    begin
        alu_op_o = ADD;

        case (alu_class_i)
            CLS_ADD:   alu_op_o = ADD;
            CLS_SUB:   alu_op_o = SUB;
            CLS_PASSB: alu_op_o = PASSB;
            CLS_FUNC:
            begin
                case (funct3_i)
                    3'b000:
                    begin
                        // addi has no SUB form, funct7 there is immediate data
                        if (op_b5_i && funct7_b5_i)
                            alu_op_o = SUB;
                        else
                            alu_op_o = ADD;
                    end
                    3'b001: alu_op_o = SLL;
                    3'b010: alu_op_o = SLT;
                    3'b011: alu_op_o = SLTU;
                    3'b100: alu_op_o = XOR;
                    3'b101:
                    begin
                        if (funct7_b5_i)  // Same bit for srai and sra
                            alu_op_o = SRA;
                        else
                            alu_op_o = SRL;
                    end
                    3'b110: alu_op_o = OR;
                    default: alu_op_o = AND;
                endcase
            end
            default: alu_op_o = ADD;
        endcase
    end

endmodule

// ==== logic/imm_extend.sv ====
`timescale 1ns/1ps

`include "riscv_ctrl_defs.svh"

module imm_extend
    import riscv_ctrl_pkg::*;
(
    input  logic [`IMM_FIELD_W-1:0] instr_i,    // Instruction bits 31 to 7
    input  imm_src_e                imm_src_i,
    output logic [`XLEN-1:0]        imm_o
);

    // Index k here is instruction bit k+7
    logic sign;

    assign sign = instr_i[24];  // Instruction bit 31

    always_comb
    begin
        case (imm_src_i)
            IMM_I: imm_o = {{(`XLEN-12){sign}}, instr_i[24:13]};
            IMM_S: imm_o = {{(`XLEN-12){sign}}, instr_i[24:18], instr_i[4:0]};
            IMM_B:
            begin
                imm_o = {{(`XLEN-12){sign}}, instr_i[0], instr_i[23:18],
                         instr_i[4:1], 1'b0};  // Halfword aligned offset
            end
            IMM_U: imm_o = {instr_i[24:5], 12'b0};
            IMM_J:
            begin
                imm_o = {{(`XLEN-20){sign}}, instr_i[12:5], instr_i[13],
                         instr_i[23:14], 1'b0};
            end
            default: imm_o = '0;
        endcase
    end

endmodule

// ==== logic/decode_pipe_reg.sv ====
`timescale 1ns/1ps

`include "riscv_ctrl_defs.svh"

module decode_pipe_reg
    import riscv_ctrl_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 stall_i,      // Hold current contents
    input  logic                 flush_i,      // Load a bubble, beats stall

    input  logic                 reg_write_i,
    input  logic                 mem_write_i,
    input  logic                 alu_src_i,
    input  logic                 pc_as_a_i,
    input  logic                 branch_i,
    input  logic                 jump_i,
    input  logic                 jalr_i,
    input  logic                 illegal_i,
    input  result_src_e          result_src_i,
    input  alu_op_e              alu_op_i,
    input  logic [`FUNCT3_W-1:0] funct3_i,
    input  logic [`XLEN-1:0]     imm_i,
    input  logic [`XLEN-1:0]     pc_i,
    input  logic [`XLEN-1:0]     pc_plus4_i,

    output logic                 reg_write_o,
    output logic                 mem_write_o,
    output logic                 alu_src_o,
    output logic                 pc_as_a_o,
    output logic                 branch_o,
    output logic                 jump_o,
    output logic                 jalr_o,
    output logic                 illegal_o,
    output result_src_e          result_src_o,
    output alu_op_e              alu_op_o,
    output logic [`FUNCT3_W-1:0] funct3_o,
    output logic [`XLEN-1:0]     imm_o,
    output logic [`XLEN-1:0]     pc_o,
    output logic [`XLEN-1:0]     pc_plus4_o
);

    logic load_en;

    assign load_en = ~stall_i;

    // Control fields
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            {reg_write_o, mem_write_o, alu_src_o, pc_as_a_o} <= '0;
            {branch_o, jump_o, jalr_o, illegal_o}           <= '0;
            result_src_o <= RES_ALU;
            alu_op_o     <= ADD;
        end
        else if (flush_i)
        begin
            {reg_write_o, mem_write_o, alu_src_o, pc_as_a_o} <= '0;
            {branch_o, jump_o, jalr_o, illegal_o}           <= '0;
            result_src_o <= RES_ALU;
            alu_op_o     <= ADD;
        end
        else if (load_en)
        begin
            {reg_write_o, mem_write_o, alu_src_o, pc_as_a_o} <=
                {reg_write_i, mem_write_i, alu_src_i, pc_as_a_i};
            {branch_o, jump_o, jalr_o, illegal_o} <= {branch_i, jump_i, jalr_i, illegal_i};
            result_src_o <= result_src_i;
            alu_op_o     <= alu_op_i;
        end
    end

    // Data fields
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            funct3_o   <= '0;
            imm_o      <= '0;
            pc_o       <= '0;
            pc_plus4_o <= '0;
        end
        else if (flush_i)
        begin
            funct3_o   <= '0;
            imm_o      <= '0;
            pc_o       <= '0;
            pc_plus4_o <= '0;
        end
        else if (load_en)
        begin
            funct3_o   <= funct3_i;
            imm_o      <= imm_i;
            pc_o       <= pc_i;
            pc_plus4_o <= pc_plus4_i;
        end
    end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

`include "riscv_ctrl_defs.svh"

module decode_stage
    import riscv_ctrl_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic [`ILEN-1:0]     instr_i,
    input  logic [`XLEN-1:0]     pc_i,
    input  logic                 stall_i,
    input  logic                 flush_i,

    output logic                 reg_write_o,
    output logic                 mem_write_o,
    output logic                 alu_src_o,
    output logic                 pc_as_a_o,
    output logic                 branch_o,
    output logic                 jump_o,
    output logic                 jalr_o,
    output logic                 illegal_o,
    output result_src_e          result_src_o,
    output alu_op_e              alu_op_o,
    output logic [`FUNCT3_W-1:0] funct3_o,  // For the branch unit
    output logic [`XLEN-1:0]     imm_o,
    output logic [`XLEN-1:0]     pc_o,
    output logic [`XLEN-1:0]     pc_plus4_o
);

    logic              reg_write;
    logic              mem_write;
    logic              alu_src;
    logic              pc_as_a;
    logic              branch;
    logic              jump;
    logic              jalr;
    logic              illegal;
    result_src_e       result_src;
    imm_src_e          imm_src;
    alu_class_e        alu_class;
    alu_op_e           alu_op;
    logic [`XLEN-1:0]  imm;
    logic [`XLEN-1:0]  pc_plus4;

    assign pc_plus4 = pc_i + `XLEN'(4);  // Link address for JAL and JALR

    main_decoder main_decoder_i (
        .op_i         (instr_i[6:0]),
        .reg_write_o  (reg_write),
        .mem_write_o  (mem_write),
        .alu_src_o    (alu_src),
        .pc_as_a_o    (pc_as_a),
        .branch_o     (branch),
        .jump_o       (jump),
        .jalr_o       (jalr),
        .illegal_o    (illegal),
        .result_src_o (result_src),
        .imm_src_o    (imm_src),
        .alu_class_o  (alu_class)
    );

    alu_decoder alu_decoder_i (
        .alu_class_i (alu_class),
        .funct3_i    (instr_i[14:12]),
        .funct7_b5_i (instr_i[30]),
        .op_b5_i     (instr_i[5]),
        .alu_op_o    (alu_op)
    );

    imm_extend imm_extend_i (
        .instr_i   (instr_i[31:7]),
        .imm_src_i (imm_src),
        .imm_o     (imm)
    );

    decode_pipe_reg decode_pipe_reg_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .reg_write_i  (reg_write),
        .mem_write_i  (mem_write),
        .alu_src_i    (alu_src),
        .pc_as_a_i    (pc_as_a),
        .branch_i     (branch),
        .jump_i       (jump),
        .jalr_i       (jalr),
        .illegal_i    (illegal),
        .result_src_i (result_src),
        .alu_op_i     (alu_op),
        .funct3_i     (instr_i[14:12]),
        .imm_i        (imm),
        .pc_i         (pc_i),
        .pc_plus4_i   (pc_plus4),
        .reg_write_o  (reg_write_o),
        .mem_write_o  (mem_write_o),
        .alu_src_o    (alu_src_o),
        .pc_as_a_o    (pc_as_a_o),
        .branch_o     (branch_o),
        .jump_o       (jump_o),
        .jalr_o       (jalr_o),
        .illegal_o    (illegal_o),
        .result_src_o (result_src_o),
        .alu_op_o     (alu_op_o),
        .funct3_o     (funct3_o),
        .imm_o        (imm_o),
        .pc_o         (pc_o),
        .pc_plus4_o   (pc_plus4_o)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk_o,
    output logic rst_n_o
);

    localparam real HALF_PERIOD  = 50.0;  // 100 ns clock
    localparam int  RESET_CYCLES = 5;

    initial
    begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial
    begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;  // Released on a rising edge
    end

endmodule

// ==== verification/tb_decode_stage.sv ====
`timescale 1ns/1ps

`include "riscv_ctrl_defs.svh"

module tb_decode_stage;

    localparam int                MAX_CASES = 64;
    localparam int                CASE_W    = 112;
    localparam logic [CASE_W-1:0] END_MARK  = '1;

    logic                 clk;
    logic                 rst_n;
    logic [`ILEN-1:0]     instr;
    logic [`XLEN-1:0]     pc;
    logic                 stall;
    logic                 flush;

    logic                 reg_write_q;
    logic                 mem_write_q;
    logic                 alu_src_q;
    logic                 pc_as_a_q;
    logic                 branch_q;
    logic                 jump_q;
    logic                 jalr_q;
    logic                 illegal_q;
    logic [1:0]           result_src_q;
    logic [3:0]           alu_op_q;
    logic [`FUNCT3_W-1:0] funct3_q;
    logic [`XLEN-1:0]     imm_q;
    logic [`XLEN-1:0]     pc_q;
    logic [`XLEN-1:0]     pc_plus4_q;

    // instr, pc, flags, result_src, alu_op, imm
    logic [CASE_W-1:0]    cases_mem [0:MAX_CASES-1];

    // Expected register contents
    logic [7:0]           exp_flags;
    logic [3:0]           exp_res;
    logic [3:0]           exp_op;
    logic [`FUNCT3_W-1:0] exp_funct3;
    logic [`XLEN-1:0]     exp_imm;
    logic [`XLEN-1:0]     exp_pc;
    logic [`XLEN-1:0]     exp_pc4;
    string                exp_tag;

    logic [31:0]          rnd;
    int                   n_cases;
    int                   applied_idx;
    int                   next_idx;
    int                   drive_count;
    int                   check_count = 0;
    int                   error_count = 0;
    int                   cycle_count = 0;
    int                   cycle_limit = 0;
    logic                 next_stall;
    logic                 next_flush;

    tb_clock_gen clock_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    decode_stage dut_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .instr_i      (instr),
        .pc_i         (pc),
        .stall_i      (stall),
        .flush_i      (flush),
        .reg_write_o  (reg_write_q),
        .mem_write_o  (mem_write_q),
        .alu_src_o    (alu_src_q),
        .pc_as_a_o    (pc_as_a_q),
        .branch_o     (branch_q),
        .jump_o       (jump_q),
        .jalr_o       (jalr_q),
        .illegal_o    (illegal_q),
        .result_src_o (result_src_q),
        .alu_op_o     (alu_op_q),
        .funct3_o     (funct3_q),
        .imm_o        (imm_q),
        .pc_o         (pc_q),
        .pc_plus4_o   (pc_plus4_q)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("** Error: %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic set_bubble(input string tag);
        exp_flags  = '0;
        exp_res    = '0;
        exp_op     = '0;
        exp_funct3 = '0;
        exp_imm    = '0;
        exp_pc     = '0;
        exp_pc4    = '0;
        exp_tag    = tag;
    endtask

    task automatic load_case(input int idx);
        logic [CASE_W-1:0] entry;
        entry      = cases_mem[idx];
        exp_flags  = entry[47:40];
        exp_res    = entry[39:36];
        exp_op     = entry[35:32];
        exp_imm    = entry[31:0];
        exp_funct3 = entry[94:92];  // Instruction bits 14 to 12
        exp_pc     = entry[79:48];
        exp_pc4    = entry[79:48] + 32'd4;
        exp_tag    = $sformatf("case %0d", idx);
    endtask

    task automatic compare_outputs();
        check_value({exp_tag, " reg_write"}, exp_flags[7], reg_write_q);
        check_value({exp_tag, " mem_write"}, exp_flags[6], mem_write_q);
        check_value({exp_tag, " alu_src"}, exp_flags[5], alu_src_q);
        check_value({exp_tag, " pc_as_a"}, exp_flags[4], pc_as_a_q);
        check_value({exp_tag, " branch"}, exp_flags[3], branch_q);
        check_value({exp_tag, " jump"}, exp_flags[2], jump_q);
        check_value({exp_tag, " jalr"}, exp_flags[1], jalr_q);
        check_value({exp_tag, " illegal"}, exp_flags[0], illegal_q);
        check_value({exp_tag, " result_src"}, exp_res[1:0], result_src_q);
        check_value({exp_tag, " alu_op"}, exp_op, alu_op_q);
        check_value({exp_tag, " funct3"}, exp_funct3, funct3_q);
        check_value({exp_tag, " imm"}, exp_imm, imm_q);
        check_value({exp_tag, " pc"}, exp_pc, pc_q);
        check_value({exp_tag, " pc_plus4"}, exp_pc4, pc_plus4_q);
    endtask

    // Stall and flush mix, with a few fixed slots so each kind occurs
    task automatic pick_controls();
        rnd = xorshift32(rnd);
        next_stall = (rnd[2:0] == 3'b000);
        next_flush = (rnd[10:8] == 3'b000);
        if (drive_count < 2)
        begin
            next_stall = 1'b1;  // Reset bubble must hold
            next_flush = 1'b0;
        end
        else if (drive_count == 12)
        begin
            next_stall = 1'b1;
            next_flush = 1'b0;
        end
        else if (drive_count == 16)
        begin
            next_stall = 1'b0;
            next_flush = 1'b1;
        end
        else if (drive_count == 20)
        begin
            next_stall = 1'b1;
            next_flush = 1'b1;
        end
    endtask

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial
    begin
        instr = `NOP_INSTR;
        pc    = '0;
        stall = 1'b1;
        flush = 1'b0;
        rnd   = 32'hd0dd8ec2;

        $readmemh("verification/decode_cases.txt", cases_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES && !$isunknown(cases_mem[n_cases])
               && cases_mem[n_cases] !== END_MARK)
            n_cases++;
        cycle_limit = n_cases * 4 + 20;
        assert (n_cases > 0)
        else
        begin
            error_count++;
            $display("No test cases could be read from the case file");
        end

        set_bubble("reset bubble");
        @(posedge rst_n);
        @(negedge clk);
        compare_outputs();

        applied_idx = -1;  // No case on the inputs yet
        next_idx    = 0;
        drive_count = 0;
        while (next_idx < n_cases || applied_idx >= 0)
        begin
            @(posedge clk);
            // Model the edge with the inputs the DUT just sampled
            if (flush)
                set_bubble("flush bubble");
            else if (!stall && applied_idx >= 0)
            begin
                load_case(applied_idx);
                next_idx = applied_idx + 1;
            end

            if (next_idx < n_cases)
            begin
                pick_controls();
                instr <= cases_mem[next_idx][111:80];
                pc    <= cases_mem[next_idx][79:48];
                stall <= next_stall;
                flush <= next_flush;
                applied_idx = next_idx;  // Re-presented until it is loaded
                drive_count++;
            end
            else
            begin
                instr <= `NOP_INSTR;
                stall <= 1'b1;
                flush <= 1'b0;
                applied_idx = -1;
            end

            @(negedge clk);
            compare_outputs();
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== verification/decode_cases.txt ====
// Columns: instr_pc_flags_resultsrc_aluop_imm (hex)
// Flags: reg_write mem_write alu_src pc_as_a branch jump jalr illegal
00500093_00001000_a0_0_0_00000005 // addi x1, x0, 5
fff08113_00001004_a0_0_0_ffffffff // addi x2, x1, -1
00209493_00001008_a0_0_2_00000002 // slli x9, x1, 2
ffc0a513_0000100c_a0_0_3_fffffffc // slti x10, x1, -4
0010b593_00001010_a0_0_4_00000001 // sltiu x11, x1, 1
fff0c613_00001014_a0_0_5_ffffffff // xori x12, x1, -1
0030d393_00001018_a0_0_6_00000003 // srli x7, x1, 3
4030d413_0000101c_a0_0_7_00000403 // srai x8, x1, 3
7ff0e693_00001020_a0_0_8_000007ff // ori x13, x1, 2047
0f00f713_00001024_a0_0_9_000000f0 // andi x14, x1, 240
002081b3_00001028_80_0_0_00000002 // add x3, x1, x2
40208233_0000102c_80_0_1_00000402 // sub x4, x1, x2
002097b3_00001030_80_0_2_00000002 // sll x15, x1, x2
0020a833_00001034_80_0_3_00000002 // slt x16, x1, x2
0020b8b3_00001038_80_0_4_00000002 // sltu x17, x1, x2
0020c933_0000103c_80_0_5_00000002 // xor x18, x1, x2
0020d2b3_00001040_80_0_6_00000002 // srl x5, x1, x2
4020d333_00001044_80_0_7_00000402 // sra x6, x1, x2
0020e9b3_00001048_80_0_8_00000002 // or x19, x1, x2
0020fa33_0000104c_80_0_9_00000002 // and x20, x1, x2
00812283_00001050_a0_1_0_00000008 // lw x5, 8(x2)
ff010303_00001054_a0_1_0_fffffff0 // lb x6, -16(x2)
00512623_00001058_60_0_0_0000000c // sw x5, 12(x2)
fe610623_0000105c_60_0_0_ffffffec // sb x6, -20(x2)
00208863_00001060_08_0_1_00000010 // beq x1, x2, +16
fe209ce3_00001064_08_0_1_fffffff8 // bne x1, x2, -8
0041c0e3_00001068_08_0_1_00000800 // blt x3, x4, +2048
001000ef_0000106c_84_2_0_00000800 // jal x1, +2048
ffdff06f_00001070_84_2_0_fffffffc // jal x0, -4
000012ef_00001074_84_2_0_00001000 // jal x5, +4096
004280e7_00001078_a6_2_0_00000004 // jalr x1, 4(x5)
ff808067_0000107c_a6_2_0_fffffff8 // jalr x0, -8(x1)
12345197_00001080_b0_0_0_12345000 // auipc x3, 0x12345
fffff217_00001084_b0_0_0_fffff000 // auipc x4, 0xfffff
deadb2b7_00001088_a0_0_a_deadb000 // lui x5, 0xdeadb
00001337_0000108c_a0_0_a_00001000 // lui x6, 0x1
0000000b_00001090_01_0_0_00000000 // custom-0 opcode
00000073_00001094_01_0_0_00000000 // ecall is not decoded here
0000000f_00001098_01_0_0_00000000 // fence is not decoded here
0000007f_0000109c_01_0_0_00000000 // reserved opcode
00000000_000010a0_01_0_0_00000000 // all-zero word
00000013_fffffffc_a0_0_0_00000000 // nop, pc+4 wraps to zero
ffffffff_ffffffff_ff_f_f_ffffffff // end marker

// ==== sim.f ====
+incdir+logic
logic/riscv_ctrl_pkg.sv
logic/main_decoder.sv
logic/alu_decoder.sv
logic/imm_extend.sv
logic/decode_pipe_reg.sv
logic/decode_stage.sv
verification/tb_clock_gen.sv
verification/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: riscv_decode_stage

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/riscv_ctrl_pkg.sv
      - logic/main_decoder.sv
      - logic/alu_decoder.sv
      - logic/imm_extend.sv
      - logic/decode_pipe_reg.sv
      - logic/decode_stage.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_decode_stage.sv
